// File: Makefile
# Verilator flow for the PMA unit
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_pma_top
RTL_TOP   ?= pma_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/pma_cfg.svh
// Region count must stay within 0..16 and PMA_ADDR_W must equal the 32-bit config data width
`ifndef PMA_CFG_SVH
`define PMA_CFG_SVH

// Number of attribute regions, legal range 0 to 16
// A count of 0 gives every access the built-in default attributes
`define PMA_NUM_REGIONS 8

// Address width of core and bus requests
// Region bounds are written through the 32-bit config port
`define PMA_ADDR_W 32

// Width of each saturating statistics counter
`define PMA_STAT_W 16

// Width of the region index on the config port, enough for 16 regions
`define PMA_IDX_W 4

// Width of the match count, holds 0 to 16
`define PMA_CNT_W 5

// Storage slots for region arrays
// Never zero so that packed ranges stay legal with no regions
`define PMA_REGION_SLOTS ((`PMA_NUM_REGIONS > 0) ? `PMA_NUM_REGIONS : 1)

`endif

// File: design/pma_gate.sv
// Single bus entry, so a stalled bus stops the core; fault_valid is a one-cycle strobe, no ack
`timescale 1ns/1ps

module pma_gate
  import pma_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       trans_valid,
  output logic       trans_ready,
  input  pma_req_t   trans_req,
  input  pma_attr_t  attr,
  output logic       bus_valid,
  input  logic       bus_ready,
  output pma_bus_t   bus_req,
  output logic       fault_valid,
  output pma_fault_t fault_info,
  output logic       accept
);

  logic entry_free;
  logic is_fault;
  logic load_bus;
  logic load_fault;

  // Entry empties on a bus handshake in the same cycle
  assign entry_free  = !bus_valid || bus_ready;
  assign trans_ready = entry_free;
  assign accept      = trans_valid && trans_ready;

  // Fetch from non-executable space is blocked
  assign is_fault   = (trans_req.kind == PMA_FETCH) && !attr.executable;
  assign load_bus   = accept && !is_fault;
  assign load_fault = accept && is_fault;

  // Bus entry valid
  // Holds under back-pressure, otherwise follows this cycle's load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_valid <= 1'b0;
    end else if (entry_free) begin
      bus_valid <= load_bus;
    end
  end

  // Bus payload, only loaded when a new request is accepted
  always_ff @(posedge clk) begin
    if (load_bus) begin
      bus_req.addr <= trans_req.addr;
      bus_req.kind <= trans_req.kind;
      bus_req.attr <= attr;
    end
  end

  // Fault strobe, high for exactly one cycle per blocked fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_valid <= 1'b0;
    end else begin
      fault_valid <= load_fault;
    end
  end

  // Fault payload
  always_ff @(posedge clk) begin
    if (load_fault) begin
      fault_info.addr <= trans_req.addr;
      fault_info.kind <= trans_req.kind;
    end
  end

endmodule

// File: design/pma_match_stats.sv
// Counters saturate and never wrap; stats_clr wins over a count landing in the same cycle
`timescale 1ns/1ps
`include "pma_cfg.svh"

module pma_match_stats
  import pma_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  accept,
  input  logic [`PMA_CNT_W-1:0] num_matches,
  input  logic                  stats_clr,
  output pma_stats_t            stats
);

  // Increment that sticks at all ones
  function automatic logic [`PMA_STAT_W-1:0] sat_inc(input logic [`PMA_STAT_W-1:0] val);
    logic [`PMA_STAT_W-1:0] res;
    res = (val == '1) ? val : val + 1'b1;
    return res;
  endfunction

  logic bin_zero;
  logic bin_one;
  logic bin_many;

  // Bin select from the match count
  assign bin_zero = (num_matches == '0);
  assign bin_one  = (num_matches == `PMA_CNT_W'(1));
  assign bin_many = !bin_zero && !bin_one;

  // Counts show up one cycle after the accepting edge
  // Faulting requests are counted too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (stats_clr) begin
      stats <= '0;
    end else if (accept) begin
      if (bin_zero) begin
        stats.zero <= sat_inc(stats.zero);
      end
      if (bin_one) begin
        stats.one <= sat_inc(stats.one);
      end
      if (bin_many) begin
        stats.many <= sat_inc(stats.many);
      end
    end
  end

endmodule

// File: design/pma_pkg.sv
// Types only; the matchlist width follows PMA_REGION_SLOTS, so it has one bit even with 0 regions
`include "pma_cfg.svh"

package pma_pkg;

  // Attribute set of one region
  // main=0 means I/O space
  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
    logic executable;
  } pma_attr_t;

  // One programmable region
  // addr_low inclusive, addr_high exclusive
  // Empty when addr_high <= addr_low
  typedef struct packed {
    logic [`PMA_ADDR_W-1:0] addr_low;
    logic [`PMA_ADDR_W-1:0] addr_high;
    pma_attr_t              attr;
  } pma_region_t;

  // Access kind of a core transaction
  typedef enum logic [1:0] {
    PMA_READ  = 2'd0,
    PMA_WRITE = 2'd1,
    PMA_FETCH = 2'd2
  } pma_kind_t;

  // Request offered by the core
  typedef struct packed {
    logic [`PMA_ADDR_W-1:0] addr;
    pma_kind_t              kind;
  } pma_req_t;

  // Request forwarded to the bus with resolved attributes
  typedef struct packed {
    logic [`PMA_ADDR_W-1:0] addr;
    pma_kind_t              kind;
    pma_attr_t              attr;
  } pma_bus_t;

  // Report of a blocked fetch
  typedef struct packed {
    logic [`PMA_ADDR_W-1:0] addr;
    pma_kind_t              kind;
  } pma_fault_t;

  // Match result for the current core address
  typedef struct packed {
    logic [`PMA_REGION_SLOTS-1:0] matchlist;
    logic [`PMA_CNT_W-1:0]        num_matches;
    pma_attr_t                    attr;
  } pma_status_t;

  // Accepted requests binned by match count
  typedef struct packed {
    logic [`PMA_STAT_W-1:0] zero;
    logic [`PMA_STAT_W-1:0] one;
    logic [`PMA_STAT_W-1:0] many;
  } pma_stats_t;

endpackage

// File: design/pma_region_match.sv
// Purely combinational; with 0 regions all accesses resolve to main, bufferable, cacheable, exec
`timescale 1ns/1ps
`include "pma_cfg.svh"

module pma_region_match
  import pma_pkg::*;
(
  input  logic [`PMA_ADDR_W-1:0]              addr,
  input  pma_region_t [`PMA_REGION_SLOTS-1:0] regions,
  output pma_status_t                         status
);

  // Attributes used when the unit has no regions at all
  localparam pma_attr_t ATTR_NO_REGIONS = '{
    main:       1'b1,
    bufferable: 1'b1,
    cacheable:  1'b1,
    executable: 1'b1
  };

  // Attributes used when regions exist but none matches
  // I/O and not executable
  localparam pma_attr_t ATTR_NO_MATCH = '0;

  logic [`PMA_REGION_SLOTS-1:0] hit;
  logic [`PMA_CNT_W-1:0]        hit_cnt;
  pma_attr_t                    win_attr;

  // Parallel bound compare
  // An empty region fails one of the two tests by itself
  always_comb begin
    hit = '0;
    for (int i = 0; i < `PMA_REGION_SLOTS; i++) begin
      if (i < `PMA_NUM_REGIONS) begin
        hit[i] = (addr >= regions[i].addr_low) && (addr < regions[i].addr_high);
      end
    end
  end

  // Population count of the matchlist
  always_comb begin
    hit_cnt = '0;
    for (int i = 0; i < `PMA_REGION_SLOTS; i++) begin
      hit_cnt = hit_cnt + `PMA_CNT_W'(hit[i]);
    end
  end

  // Priority pick
  // Walk downward so the lowest matching index is written last
  always_comb begin
    if (`PMA_NUM_REGIONS == 0) begin
      win_attr = ATTR_NO_REGIONS;
    end else begin
      win_attr = ATTR_NO_MATCH;
      for (int i = `PMA_REGION_SLOTS - 1; i >= 0; i--) begin
        if (hit[i]) begin
          win_attr = regions[i].attr;
        end
      end
    end
  end

  // Status bundle for the gate and the statistics block
  always_comb begin
    status             = '0;
    status.matchlist   = hit;
    status.num_matches = hit_cnt;
    status.attr        = win_attr;
  end

endmodule

// File: design/pma_region_regs.sv
// Writes to an index at or above PMA_NUM_REGIONS are dropped and such reads return zero
`timescale 1ns/1ps
`include "pma_cfg.svh"

module pma_region_regs
  import pma_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfg_we,
  input  logic [`PMA_IDX_W-1:0]               cfg_index,
  input  logic [1:0]                          cfg_field,
  input  logic [31:0]                         cfg_wdata,
  output logic [31:0]                         cfg_rdata,
  output pma_region_t [`PMA_REGION_SLOTS-1:0] regions
);

  // Field codes on cfg_field
  localparam logic [1:0] FIELD_LOW  = 2'd0;
  localparam logic [1:0] FIELD_HIGH = 2'd1;
  localparam logic [1:0] FIELD_ATTR = 2'd2;

  localparam int ATTR_W = $bits(pma_attr_t);

  // Region table
  pma_region_t [`PMA_REGION_SLOTS-1:0] region_q;

  // One-hot select of the addressed region
  logic [`PMA_REGION_SLOTS-1:0] sel;

  // Only implemented slots can be selected
  // With 0 regions the single spare slot stays unselected
  always_comb begin
    for (int i = 0; i < `PMA_REGION_SLOTS; i++) begin
      sel[i] = (i < `PMA_NUM_REGIONS) && (cfg_index == `PMA_IDX_W'(i));
    end
  end

  // Strobed field writes, visible from the next edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      region_q <= '0;
    end else if (cfg_we) begin
      for (int i = 0; i < `PMA_REGION_SLOTS; i++) begin
        if (sel[i]) begin
          case (cfg_field)
            FIELD_LOW:  region_q[i].addr_low  <= cfg_wdata;
            FIELD_HIGH: region_q[i].addr_high <= cfg_wdata;
            // Only the low bits carry attributes
            FIELD_ATTR: region_q[i].attr      <= pma_attr_t'(cfg_wdata[ATTR_W-1:0]);
            default: ;
          endcase
        end
      end
    end
  end

  // Combinational readback of the same index and field
  always_comb begin
    cfg_rdata = '0;
    for (int i = 0; i < `PMA_REGION_SLOTS; i++) begin
      if (sel[i]) begin
        case (cfg_field)
          FIELD_LOW:  cfg_rdata = region_q[i].addr_low;
          FIELD_HIGH: cfg_rdata = region_q[i].addr_high;
          // Upper bits read as zero
          FIELD_ATTR: cfg_rdata = {{(32-ATTR_W){1'b0}}, region_q[i].attr};
          default:    cfg_rdata = '0;
        endcase
      end
    end
  end

  // Table goes straight to the matcher
  assign regions = region_q;

endmodule

// File: design/pma_top.sv
// Bus port is request only; matching uses the current trans_req, so writes apply next cycle
`timescale 1ns/1ps
`include "pma_cfg.svh"

module pma_top
  import pma_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Region configuration
  input  logic                  cfg_we,
  input  logic [`PMA_IDX_W-1:0] cfg_index,
  input  logic [1:0]            cfg_field,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata,
  // Core side
  input  logic                  trans_valid,
  output logic                  trans_ready,
  input  pma_req_t              trans_req,
  // Bus side
  output logic                  bus_valid,
  input  logic                  bus_ready,
  output pma_bus_t              bus_req,
  // Fault report
  output logic                  fault_valid,
  output pma_fault_t            fault_info,
  // Statistics
  input  logic                  stats_clr,
  output pma_stats_t            stats
);

  pma_region_t [`PMA_REGION_SLOTS-1:0] regions;
  pma_status_t                         status;
  logic                                accept;

  pma_region_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_index (cfg_index),
    .cfg_field (cfg_field),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .regions   (regions)
  );

  // Matches the address the core is offering right now
  pma_region_match u_match (
    .addr    (trans_req.addr),
    .regions (regions),
    .status  (status)
  );

  pma_gate u_gate (
    .clk         (clk),
    .rst_n       (rst_n),
    .trans_valid (trans_valid),
    .trans_ready (trans_ready),
    .trans_req   (trans_req),
    .attr        (status.attr),
    .bus_valid   (bus_valid),
    .bus_ready   (bus_ready),
    .bus_req     (bus_req),
    .fault_valid (fault_valid),
    .fault_info  (fault_info),
    .accept      (accept)
  );

  // Binned on the same handshake the gate accepts
  pma_match_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept      (accept),
    .num_matches (status.num_matches),
    .stats_clr   (stats_clr),
    .stats       (stats)
  );

endmodule

// File: sim/tb_pma_top.sv
// Expects the default of 8 regions; bus_ready stays high except while the back-pressure test runs
`timescale 1ns/1ps
`include "pma_cfg.svh"

module tb_pma_top
  import pma_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 5000;

  logic        clk;
  logic        rst_n;
  logic        cfg_we;
  logic [3:0]  cfg_index;
  logic [1:0]  cfg_field;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;
  logic        trans_valid;
  logic        trans_ready;
  pma_req_t    trans_req;
  logic        bus_valid;
  logic        bus_ready;
  pma_bus_t    bus_req;
  logic        fault_valid;
  pma_fault_t  fault_info;
  logic        stats_clr;
  pma_stats_t  stats;

  // Reference model state
  pma_region_t m_reg [16];
  pma_bus_t    exp_bus [$];
  pma_fault_t  exp_fault [$];
  pma_stats_t  exp_stats;
  int          err_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  // Back-pressure tracking for the monitor
  logic        stalled = 1'b0;
  pma_bus_t    held_req;

  pma_top UUT (
    .clk(clk), .rst_n(rst_n),
    .cfg_we(cfg_we), .cfg_index(cfg_index), .cfg_field(cfg_field),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .trans_valid(trans_valid), .trans_ready(trans_ready), .trans_req(trans_req),
    .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_req(bus_req),
    .fault_valid(fault_valid), .fault_info(fault_info),
    .stats_clr(stats_clr), .stats(stats)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit well above the summed test lengths
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_bus(input string name, input pma_bus_t got, input pma_bus_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_fault(input string name, input pma_fault_t got, input pma_fault_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_stats(input string name, input pma_stats_t got, input pma_stats_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  function automatic pma_bus_t make_bus(input logic [31:0] addr, input pma_kind_t kind,
                                        input logic [3:0] attr);
    pma_bus_t b;
    b.addr = addr;
    b.kind = kind;
    b.attr = pma_attr_t'(attr);
    return b;
  endfunction

  // Lowest matching index wins; no regions at all means fully permissive
  function automatic void resolve(input logic [31:0] addr, output pma_attr_t attr,
                                  output int hits);
    attr = (`PMA_NUM_REGIONS == 0) ? pma_attr_t'(4'hF) : pma_attr_t'(4'h0);
    hits = 0;
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (m_reg[i].addr_low <= addr && addr < m_reg[i].addr_high) begin
        if (hits == 0) attr = m_reg[i].attr;
        hits++;
      end
    end
  endfunction

  // Monitor samples at the falling edge away from input and register updates
  always @(negedge clk) begin
    if (rst_n) begin
      if (stalled) begin
        check_flag("bus_valid", bus_valid, 1'b1);
        check_bus("bus_req held", bus_req, held_req);
      end
      if (bus_valid && !bus_ready) check_flag("trans_ready", trans_ready, 1'b0);
      if (bus_valid && bus_ready) begin
        if (exp_bus.size() == 0) begin
          $display("Error at %0t ns: bus request seen when none was expected", $time);
          err_count++;
        end else begin
          check_bus("bus_req", bus_req, exp_bus.pop_front());
        end
      end
      if (fault_valid) begin
        if (exp_fault.size() == 0) begin
          $display("Error at %0t ns: fault strobe seen when none was expected", $time);
          err_count++;
        end else begin
          check_fault("fault_info", fault_info, exp_fault.pop_front());
        end
      end
      stalled  = bus_valid && !bus_ready;
      held_req = bus_req;
    end
  end

  // All tasks below start and end 1 ns after a rising edge
  task automatic cfg_write(input logic [3:0] idx, input logic [1:0] field,
                           input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_index = idx;
    cfg_field = field;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    if (idx < `PMA_NUM_REGIONS) begin
      case (field)
        2'd0: m_reg[idx].addr_low = data;
        2'd1: m_reg[idx].addr_high = data;
        2'd2: m_reg[idx].attr = pma_attr_t'(data[3:0]);
        default: ;
      endcase
    end
  endtask

  task automatic cfg_read(input logic [3:0] idx, input logic [1:0] field,
                          input logic [31:0] exp);
    cfg_index = idx;
    cfg_field = field;
    @(negedge clk);
    check_rdata($sformatf("cfg_rdata[%0d.%0d]", idx, field), cfg_rdata, exp);
    @(posedge clk);
    #1;
  endtask

  task automatic program_region(input logic [3:0] idx, input logic [31:0] low,
                                input logic [31:0] high, input logic [31:0] attr);
    cfg_write(idx, 2'd0, low);
    cfg_write(idx, 2'd1, high);
    cfg_write(idx, 2'd2, attr);
  endtask

  // Attribute readback keeps only the low four bits
  task automatic check_region(input logic [3:0] idx, input logic [31:0] low,
                              input logic [31:0] high, input logic [31:0] attr);
    cfg_read(idx, 2'd0, low);
    cfg_read(idx, 2'd1, high);
    cfg_read(idx, 2'd2, attr & 32'hF);
  endtask

  task automatic count_match(input int hits);
    if (hits == 0 && exp_stats.zero != '1) exp_stats.zero += 1;
    if (hits == 1 && exp_stats.one != '1) exp_stats.one += 1;
    if (hits > 1 && exp_stats.many != '1) exp_stats.many += 1;
  endtask

  // Offer one request, wait for the handshake, then check the one-cycle latency
  task automatic send_req(input logic [31:0] addr, input pma_kind_t kind);
    pma_attr_t  attr;
    int         hits;
    logic       fault;
    pma_fault_t f;
    trans_valid    = 1'b1;
    trans_req.addr = addr;
    trans_req.kind = kind;
    do @(negedge clk); while (!trans_ready);
    resolve(addr, attr, hits);
    fault = (kind == PMA_FETCH) && !attr.executable;
    f.addr = addr;
    f.kind = kind;
    if (fault) exp_fault.push_back(f);
    else exp_bus.push_back(make_bus(addr, kind, attr));
    count_match(hits);
    @(posedge clk);
    #1;
    trans_valid = 1'b0;
    check_flag("bus_valid", bus_valid, !fault);
    check_flag("fault_valid", fault_valid, fault);
  endtask

  task automatic drain_and_check();
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    if (exp_bus.size() != 0 || exp_fault.size() != 0) begin
      $display("Error at %0t ns: %0d bus and %0d fault results never arrived",
               $time, exp_bus.size(), exp_fault.size());
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("[%0t ns] %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t ns] %s: FAILED with %0d errors", $time, name, err_count - errs_before);
    end
  endtask

  task automatic test_cfg_readback();
    int errs;
    errs = err_count;
    program_region(4'd0, 32'h0000_1000, 32'h0000_2000, 32'hA5A5_A5AF);
    program_region(4'd2, 32'h0001_0000, 32'h0002_0000, 32'h0000_0036);
    program_region(4'd5, 32'h0003_0000, 32'h0003_8000, 32'h1234_5678);
    // Region 7 is empty with high below low
    program_region(4'd7, 32'h0000_5000, 32'h0000_4000, 32'hFFFF_FFFF);
    check_region(4'd0, 32'h0000_1000, 32'h0000_2000, 32'hA5A5_A5AF);
    check_region(4'd2, 32'h0001_0000, 32'h0002_0000, 32'h0000_0036);
    check_region(4'd5, 32'h0003_0000, 32'h0003_8000, 32'h1234_5678);
    check_region(4'd7, 32'h0000_5000, 32'h0000_4000, 32'hFFFF_FFFF);
    cfg_read(4'd3, 2'd1, 32'h0);
    // Indices past the region count
    program_region(4'd8, 32'hDEAD_BEEF, 32'hFFFF_FFFF, 32'hF);
    cfg_write(4'd15, 2'd0, 32'h0000_0100);
    check_region(4'd8, 32'h0, 32'h0, 32'h0);
    cfg_read(4'd15, 2'd0, 32'h0);
    check_region(4'd0, 32'h0000_1000, 32'h0000_2000, 32'hA5A5_A5AF);
    finish_test("config readback", errs);
  endtask

  task automatic test_overlap();
    int errs;
    errs = err_count;
    program_region(4'd1, 32'h0010_0000, 32'h0020_0000, 32'h9);
    program_region(4'd4, 32'h0018_0000, 32'h0030_0000, 32'h6);
    send_req(32'h0018_0000, PMA_READ);
    check_bus("bus_req overlap", bus_req, make_bus(32'h0018_0000, PMA_READ, 4'h9));
    send_req(32'h001F_FFFC, PMA_READ);
    send_req(32'h0019_0040, PMA_WRITE);
    // Region 4 alone
    send_req(32'h0025_0000, PMA_READ);
    drain_and_check();
    finish_test("overlap priority", errs);
  endtask

  task automatic test_default_fault();
    int errs;
    errs = err_count;
    send_req(32'h8000_0000, PMA_READ);
    check_bus("bus_req default", bus_req, make_bus(32'h8000_0000, PMA_READ, 4'h0));
    send_req(32'h8000_0000, PMA_FETCH);
    @(posedge clk);
    #1;
    check_flag("fault_valid second cycle", fault_valid, 1'b0);
    send_req(32'h0000_1800, PMA_FETCH);
    check_bus("bus_req fetch", bus_req, make_bus(32'h0000_1800, PMA_FETCH, 4'hF));
    drain_and_check();
    finish_test("default and fault", errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    errs = err_count;
    bus_ready = 1'b0;
    fork
      begin
        send_req(32'h0000_1000, PMA_WRITE);
        send_req(32'h0001_0004, PMA_READ);
        send_req(32'h8000_0010, PMA_WRITE);
        send_req(32'h0018_0008, PMA_READ);
      end
      begin
        repeat (6) @(posedge clk);
        #1;
        if (exp_bus.size() != 1) begin
          $display("Error at %0t ns: %0d requests taken while the bus stalled",
                   $time, exp_bus.size());
          err_count++;
        end
        bus_ready = 1'b1;
      end
    join
    drain_and_check();
    finish_test("back-pressure", errs);
  endtask

  task automatic test_stats();
    int          errs;
    logic [31:0] addr;
    errs = err_count;
    for (int n = 0; n < 40; n++) begin
      case ($urandom % 4)
        0: addr = 32'h0000_1000 + ($urandom % 32'h1000);
        1: addr = 32'h0010_0000 + ($urandom % 32'h0020_0000);
        2: addr = 32'h8000_0000 + ($urandom % 32'h1000);
        default: addr = 32'h0002_0000 + ($urandom % 32'h0002_0000);
      endcase
      send_req(addr, pma_kind_t'(2'($urandom % 3)));
    end
    drain_and_check();
    check_stats("stats", stats, exp_stats);
    stats_clr = 1'b1;
    @(posedge clk);
    #1;
    stats_clr = 1'b0;
    exp_stats = '0;
    check_stats("stats after clear", stats, exp_stats);
    finish_test("statistics", errs);
  endtask

  initial begin
    void'($urandom(32'h6549915a));
    // Times print as whole nanoseconds
    $timeformat(-9, 0, "", 0);
    rst_n       = 1'b0;
    cfg_we      = 1'b0;
    cfg_index   = '0;
    cfg_field   = '0;
    cfg_wdata   = '0;
    trans_valid = 1'b0;
    trans_req   = '0;
    bus_ready   = 1'b1;
    stats_clr   = 1'b0;
    exp_stats   = '0;
    for (int i = 0; i < 16; i++) m_reg[i] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle state out of reset
    check_flag("trans_ready", trans_ready, 1'b1);
    check_flag("bus_valid", bus_valid, 1'b0);
    check_flag("fault_valid", fault_valid, 1'b0);
    check_stats("stats", stats, exp_stats);
    test_cfg_readback();
    test_overlap();
    test_default_fault();
    test_back_pressure();
    test_stats();
    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/pma_pkg.sv
design/pma_region_regs.sv
design/pma_region_match.sv
design/pma_gate.sv
design/pma_match_stats.sv
design/pma_top.sv
sim/tb_pma_top.sv
